//--- sounder_pkg.sv
// Sounder signal types
package sounder_pkg;

   localparam int SAMPLE_W = 16;     // Converter sample width
   localparam int DEGREE_W = 5;      // Wide enough for degree 16
   localparam int CODE_W   = 16;     // Longest LFSR register

   // Signed I or Q sample
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   typedef logic [DEGREE_W-1:0] degree_t;     // LFSR register length
   typedef logic [CODE_W-1:0]   mask_t;       // Galois feedback parity mask
   typedef logic [CODE_W-1:0]   code_len_t;   // PN period in chips

   // Supported degree range
   localparam int DEGREE_MIN = 2;
   localparam int DEGREE_MAX = 16;

   localparam sample_t CHIP_AMP  = 16'sd16383;   // Half scale per chip
   localparam mask_t   LFSR_SEED = 16'h0001;     // State after restart

   // One Galois step
   // Shift right and fold the mask back in when the chip is 1
   function automatic mask_t lfsr_step(input mask_t state, input mask_t mask);
      mask_t nxt;
      nxt = state >> 1;
      if (state[0]) begin
         nxt = nxt ^ mask;         // Feedback taps
      end
      return nxt;
   endfunction

endpackage

//--- sounder_regs_pkg.sv
// Sounder register map
package sounder_regs_pkg;

   localparam int WB_ADR_W = 4;      // Word address
   localparam int WB_DAT_W = 32;

   typedef logic [WB_ADR_W-1:0] wb_adr_t;
   typedef logic [WB_DAT_W-1:0] wb_dat_t;

   // Register addresses
   localparam wb_adr_t REG_DEGREE = 4'd0;   // LFSR degree in low bits
   localparam wb_adr_t REG_MODE   = 4'd1;   // Operating mode bits

   // Mode register bits
   localparam int MODE_LOOPBACK = 0;         // Digital loopback enable

endpackage

//--- sounder_regs.sv
// Wishbone configuration registers
`timescale 1ns/1ps

module sounder_regs (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      wb_cyc_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_we_i,
   input  sounder_regs_pkg::wb_adr_t wb_adr_i,
   input  sounder_regs_pkg::wb_dat_t wb_dat_i,
   output sounder_regs_pkg::wb_dat_t wb_dat_o,
   output logic                      wb_ack_o,
   output sounder_pkg::degree_t      degree_o,
   output logic                      loopback_o
);
   import sounder_pkg::*;
   import sounder_regs_pkg::*;

   logic    access;      // New cycle seen and not yet acked
   wb_dat_t rd_data;     // Read mux output

   assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

   // Read decode
   always_comb begin
      rd_data = '0;                                   // Unmapped reads zero
      case (wb_adr_i)
         REG_DEGREE: rd_data[DEGREE_W-1:0] = degree_o;
         REG_MODE:   rd_data[MODE_LOOPBACK] = loopback_o;
         default: ;
      endcase
   end

   // One-shot ack, low for a cycle between accesses
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= access;
      end
   end

   // Writes land on the edge that raises ack
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         degree_o   <= '0;                            // Invalid degree keeps sounder idle
         loopback_o <= 1'b0;
      end else if (access && wb_we_i) begin
         if (wb_adr_i == REG_DEGREE) begin
            degree_o <= wb_dat_i[DEGREE_W-1:0];
         end
         if (wb_adr_i == REG_MODE) begin
            loopback_o <= wb_dat_i[MODE_LOOPBACK];
         end
      end
   end

   // Read data valid while ack is high
   always_ff @(posedge clk_i) begin
      if (access) begin
         wb_dat_o <= rd_data;
      end
   end

endmodule

//--- lfsr_constants.sv
// LFSR degree lookup
`timescale 1ns/1ps

module lfsr_constants (
   input  sounder_pkg::degree_t   degree_i,
   output sounder_pkg::mask_t     mask_o,
   output sounder_pkg::code_len_t len_o
);
   import sounder_pkg::*;

   logic            valid;       // Degree inside supported range
   logic [CODE_W:0] len_full;    // Extra bit holds 2^16

   assign valid = (int'(degree_i) >= DEGREE_MIN) && (int'(degree_i) <= DEGREE_MAX);

   // Maximal length is 2^degree - 1
   assign len_full = ({{CODE_W{1'b0}}, 1'b1} << degree_i) - 1'b1;
   assign len_o    = valid ? len_full[CODE_W-1:0] : '0;   // Zero length idles coders

   // Maximal-length Galois masks for a right-shifting register
   always_comb begin
      case (degree_i)
         5'd2:    mask_o = 16'h0003;
         5'd3:    mask_o = 16'h0005;
         5'd4:    mask_o = 16'h0009;
         5'd5:    mask_o = 16'h0012;
         5'd6:    mask_o = 16'h0021;
         5'd7:    mask_o = 16'h0041;
         5'd8:    mask_o = 16'h008E;
         5'd9:    mask_o = 16'h0108;
         5'd10:   mask_o = 16'h0204;
         5'd11:   mask_o = 16'h0402;
         5'd12:   mask_o = 16'h0829;
         5'd13:   mask_o = 16'h100D;
         5'd14:   mask_o = 16'h2015;
         5'd15:   mask_o = 16'h4001;
         5'd16:   mask_o = 16'h8016;
         default: mask_o = '0;     // Out of range, no feedback
      endcase
   end

endmodule

//--- sounder_tx.sv
// PN code transmitter
`timescale 1ns/1ps

module sounder_tx (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 ena_i,
   input  logic                 strobe_i,
   input  logic                 loopback_i,
   input  sounder_pkg::mask_t   mask_i,
   output sounder_pkg::sample_t tx_dac_i_o,
   output sounder_pkg::sample_t tx_dac_q_o,
   output sounder_pkg::sample_t tx_sample_i_o,
   output sounder_pkg::sample_t tx_sample_q_o,
   output logic                 tx_sample_stb_o
);
   import sounder_pkg::*;

   mask_t lfsr;        // Code state with current chip in bit 0
   logic  idle;        // Disabled or no valid code
   logic  step;        // Advance one chip this cycle

   assign idle = ~ena_i | (mask_i == '0);
   assign step = strobe_i & ~idle;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || idle) begin
         lfsr            <= LFSR_SEED;       // Restart from seed
         tx_sample_i_o   <= '0;
         tx_sample_stb_o <= 1'b0;
      end else begin
         tx_sample_stb_o <= step;            // One cycle behind strobe_i
         if (step) begin
            lfsr          <= lfsr_step(lfsr, mask_i);
            tx_sample_i_o <= lfsr[0] ? CHIP_AMP : -CHIP_AMP;   // Antipodal chip
         end
      end
   end

   // Code goes out on I only
   assign tx_sample_q_o = '0;

   // DACs blanked in loopback
   assign tx_dac_i_o = loopback_i ? '0 : tx_sample_i_o;
   assign tx_dac_q_o = loopback_i ? '0 : tx_sample_q_o;

endmodule

//--- sounder_rx.sv
// Lag-sweeping PN correlator
`timescale 1ns/1ps

module sounder_rx #(
   parameter int ACC_W = 32                      // Accumulator width
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   ena_i,
   input  logic                   rx_strobe_i,
   input  logic                   loopback_i,
   input  sounder_pkg::sample_t   rx_adc_i_i,
   input  sounder_pkg::sample_t   rx_adc_q_i,
   input  sounder_pkg::sample_t   tx_sample_i_i,
   input  sounder_pkg::sample_t   tx_sample_q_i,
   input  logic                   tx_sample_stb_i,
   input  sounder_pkg::mask_t     mask_i,
   input  sounder_pkg::code_len_t len_i,
   input  sounder_pkg::degree_t   degree_i,
   output sounder_pkg::sample_t   rx_imp_i_o,
   output sounder_pkg::sample_t   rx_imp_q_o,
   output logic                   rx_strobe_o
);
   import sounder_pkg::*;

   typedef logic signed [ACC_W-1:0] acc_t;

   sample_t   in_i;          // Selected input samples
   sample_t   in_q;
   logic      in_stb;
   logic      idle;          // Disabled or no valid code
   logic      accept;        // Sample enters correlator
   logic      last;          // Sample closes the period
   logic      slip;          // Skip a chip on next sample
   mask_t     ref_lfsr;      // Local code copy
   mask_t     ref_now;       // Reference after any slip
   logic      chip;
   code_len_t count;         // Samples so far this period
   acc_t      acc_i;
   acc_t      acc_q;
   acc_t      ext_i;         // Sign-extended inputs
   acc_t      ext_q;
   acc_t      sum_i;         // Accumulator plus this sample
   acc_t      sum_q;

   // Input select
   assign in_i   = loopback_i ? tx_sample_i_i : rx_adc_i_i;
   assign in_q   = loopback_i ? tx_sample_q_i : rx_adc_q_i;
   assign in_stb = loopback_i ? tx_sample_stb_i : rx_strobe_i;

   assign idle   = ~ena_i | (len_i == '0);
   assign accept = in_stb & ~idle;
   assign last   = (count >= len_i - 1'b1);

   // Slip advances the lag by one chip per period
   assign ref_now = slip ? lfsr_step(ref_lfsr, mask_i) : ref_lfsr;
   assign chip    = ref_now[0];

   assign ext_i = acc_t'(in_i);
   assign ext_q = acc_t'(in_q);
   assign sum_i = chip ? acc_i + ext_i : acc_i - ext_i;   // Chip 1 adds
   assign sum_q = chip ? acc_q + ext_q : acc_q - ext_q;

   // Correlator control and accumulation
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || idle) begin
         ref_lfsr    <= LFSR_SEED;
         count       <= '0;
         slip        <= 1'b0;         // First period is lag 0
         acc_i       <= '0;
         acc_q       <= '0;
         rx_strobe_o <= 1'b0;
      end else begin
         rx_strobe_o <= accept & last;
         if (accept) begin
            ref_lfsr <= lfsr_step(ref_now, mask_i);
            slip     <= last;
            if (last) begin
               count <= '0;
               acc_i <= '0;          // Fresh integration
               acc_q <= '0;
            end else begin
               count <= count + 1'b1;
               acc_i <= sum_i;
               acc_q <= sum_q;
            end
         end
      end
   end

   // Impulse sample, scaled by code length and held until next period
   always_ff @(posedge clk_i) begin
      if (accept && last) begin
         rx_imp_i_o <= sample_t'(sum_i >>> degree_i);
         rx_imp_q_o <= sample_t'(sum_q >>> degree_i);
      end
   end

endmodule

//--- sounder.sv
// Channel sounder top level
`timescale 1ns/1ps

module sounder #(
   parameter int ACC_W = 32                      // Correlator accumulator width
) (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   // Wishbone slave
   input  logic                      wb_cyc_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_we_i,
   input  sounder_regs_pkg::wb_adr_t wb_adr_i,
   input  sounder_regs_pkg::wb_dat_t wb_dat_i,
   output sounder_regs_pkg::wb_dat_t wb_dat_o,
   output logic                      wb_ack_o,
   // Transmit side
   input  logic                      tx_enable_i,
   input  logic                      tx_strobe_i,    // DAC sample request
   output sounder_pkg::sample_t      tx_dac_i_o,
   output sounder_pkg::sample_t      tx_dac_q_o,
   // Receive side
   input  logic                      rx_enable_i,
   input  logic                      rx_strobe_i,    // ADC sample ready
   input  sounder_pkg::sample_t      rx_adc_i_i,
   input  sounder_pkg::sample_t      rx_adc_q_i,
   output sounder_pkg::sample_t      rx_imp_i_o,     // Impulse response to Rx FIFO
   output sounder_pkg::sample_t      rx_imp_q_o,
   output logic                      rx_strobe_o
);
   import sounder_pkg::*;

   degree_t   degree;         // Configured LFSR length
   logic      loopback;
   mask_t     mask;
   code_len_t code_len;
   sample_t   tx_smp_i;       // Internal loopback path
   sample_t   tx_smp_q;
   logic      tx_smp_stb;

   sounder_regs regs_i (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
      .wb_ack_o(wb_ack_o), .degree_o(degree), .loopback_o(loopback)
   );

   lfsr_constants constants_i (
      .degree_i(degree), .mask_o(mask), .len_o(code_len)
   );

   sounder_tx tx_i (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .ena_i(tx_enable_i),
      .strobe_i(tx_strobe_i), .loopback_i(loopback), .mask_i(mask),
      .tx_dac_i_o(tx_dac_i_o), .tx_dac_q_o(tx_dac_q_o),
      .tx_sample_i_o(tx_smp_i), .tx_sample_q_o(tx_smp_q), .tx_sample_stb_o(tx_smp_stb)
   );

   sounder_rx #(.ACC_W(ACC_W)) rx_i (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .ena_i(rx_enable_i),
      .rx_strobe_i(rx_strobe_i), .loopback_i(loopback),
      .rx_adc_i_i(rx_adc_i_i), .rx_adc_q_i(rx_adc_q_i),
      .tx_sample_i_i(tx_smp_i), .tx_sample_q_i(tx_smp_q), .tx_sample_stb_i(tx_smp_stb),
      .mask_i(mask), .len_i(code_len), .degree_i(degree),
      .rx_imp_i_o(rx_imp_i_o), .rx_imp_q_o(rx_imp_q_o), .rx_strobe_o(rx_strobe_o)
   );

endmodule

//--- sounder_chk.sv
// Sounder protocol assertions
`timescale 1ns/1ps

module sounder_chk (
   input logic                 clk_i,
   input logic                 rst_n_i,
   input logic                 wb_cyc_i,
   input logic                 wb_stb_i,
   input logic                 wb_ack_i,      // Slave ack from the DUT
   input logic                 rx_strobe_i,   // Impulse output strobe
   input logic                 loopback_i,    // Mode register bit
   input sounder_pkg::sample_t dac_i_i,
   input sounder_pkg::sample_t dac_q_i
);
   int fail_cnt = 0;     // Count of failed assertions

   // Ack starts only inside a bus cycle
   ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(wb_ack_i) |-> $past(wb_cyc_i && wb_stb_i))
      else begin
         $error("wb_ack_o rose without cyc and stb");
         fail_cnt++;
      end

   ack_one_shot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wb_ack_i |=> !wb_ack_i)
      else begin
         $error("wb_ack_o held for two cycles");
         fail_cnt++;
      end

   // Impulse strobe is a single pulse
   rx_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rx_strobe_i |=> !rx_strobe_i)
      else begin
         $error("rx_strobe_o held for two cycles");
         fail_cnt++;
      end

   dac_blank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      loopback_i |-> (dac_i_i == '0 && dac_q_i == '0))
      else begin
         $error("DAC outputs not zero in loopback");
         fail_cnt++;
      end

endmodule

//--- tb_sounder.sv
// Channel sounder testbench
`timescale 1ns/1ps

module tb_sounder;
   import sounder_pkg::*;
   import sounder_regs_pkg::*;

   localparam int ACC_W  = 32;
   localparam int T2_STB = 62;      // Two periods of degree 5
   localparam int T3_STB = 225;     // 15 periods of degree 4
   localparam int T4_STB = 56;      // 8 periods of degree 3
   localparam int T5_STB = 20;
   localparam int T6_STB = 30;
   localparam int TIMEOUT_CYCLES = (T2_STB + T3_STB + T4_STB + T5_STB + T6_STB) * 5 + 1000;

   logic    clk_i, rst_n_i;
   logic    wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   wb_adr_t wb_adr_i;
   wb_dat_t wb_dat_i, wb_dat_o;
   logic    tx_enable_i, tx_strobe_i, rx_enable_i, rx_strobe_i, rx_strobe_o;
   sample_t tx_dac_i_o, tx_dac_q_o, rx_adc_i_i, rx_adc_q_i, rx_imp_i_o, rx_imp_q_o;

   int cycle_cnt = 0;
   int check_cnt = 0, err_cnt = 0, err_base = 0;
   int test_num = 0, test_pass = 0, test_fail = 0;

   // Reference model state
   degree_t m_degree;
   logic    m_loopback;
   mask_t   m_mask, m_tx, m_ref;
   int      m_len, m_count;
   logic    m_slip;
   longint  m_acc_i, m_acc_q;

   logic        dac_due;                        // DAC check pending on next tick
   logic [15:0] dac_exp;
   logic [15:0] dac_seen[$];
   int          imp_due[$];                     // Cycle of each expected rx_strobe_o
   sample_t     imp_exp_i[$], imp_exp_q[$];
   sample_t     imp_seen[$];

   sounder #(.ACC_W(ACC_W)) dut_i (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .tx_enable_i(tx_enable_i), .tx_strobe_i(tx_strobe_i),
      .tx_dac_i_o(tx_dac_i_o), .tx_dac_q_o(tx_dac_q_o),
      .rx_enable_i(rx_enable_i), .rx_strobe_i(rx_strobe_i),
      .rx_adc_i_i(rx_adc_i_i), .rx_adc_q_i(rx_adc_q_i),
      .rx_imp_i_o(rx_imp_i_o), .rx_imp_q_o(rx_imp_q_o), .rx_strobe_o(rx_strobe_o)
   );

   bind sounder sounder_chk chk_i (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_ack_i(wb_ack_o), .rx_strobe_i(rx_strobe_o), .loopback_i(loopback),
      .dac_i_i(tx_dac_i_o), .dac_q_i(tx_dac_q_o)
   );

   always #50 clk_i = ~clk_i;                   // 100 ns period

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: run passed %0d cycles", TIMEOUT_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // Maximal taps for the degrees under test, others idle
   function automatic mask_t taps_for(degree_t d);
      case (d)
         5'd3:    return 16'h0005;
         5'd4:    return 16'h0009;
         5'd5:    return 16'h0012;
         default: return '0;
      endcase
   endfunction

   function automatic mask_t galois_next(mask_t s, mask_t taps);
      return s[0] ? ((s >> 1) ^ taps) : (s >> 1);     // Fold taps when chip is 1
   endfunction

   task automatic model_restart();
      m_tx    = LFSR_SEED;
      m_ref   = LFSR_SEED;
      m_count = 0;
      m_slip  = 1'b0;
      m_acc_i = 0;
      m_acc_q = 0;
   endtask

   // One strobe through the transmitter and the correlator
   task automatic model_strobe(input sample_t adc_i, input sample_t adc_q,
                               output logic [15:0] dexp, output logic fire,
                               output sample_t ei, output sample_t eq);
      sample_t tx_smp, in_i, in_q;
      mask_t   ref_now;
      longint  sum_i, sum_q, sh_i, sh_q;
      fire   = 1'b0;
      ei     = '0;
      eq     = '0;
      tx_smp = '0;
      if (m_mask != '0) begin
         tx_smp = m_tx[0] ? CHIP_AMP : -CHIP_AMP;
         m_tx   = galois_next(m_tx, m_mask);
      end
      dexp = m_loopback ? 16'h0000 : tx_smp;          // Blanked DACs
      in_i = m_loopback ? tx_smp : adc_i;
      in_q = m_loopback ? 16'sd0 : adc_q;
      if (m_len != 0) begin
         ref_now = m_slip ? galois_next(m_ref, m_mask) : m_ref;   // Lag slip
         m_ref   = galois_next(ref_now, m_mask);
         sum_i   = ref_now[0] ? m_acc_i + longint'(in_i) : m_acc_i - longint'(in_i);
         sum_q   = ref_now[0] ? m_acc_q + longint'(in_q) : m_acc_q - longint'(in_q);
         if (m_count == m_len - 1) begin
            fire    = 1'b1;
            sh_i    = sum_i >>> m_degree;
            sh_q    = sum_q >>> m_degree;
            ei      = sh_i[15:0];
            eq      = sh_q[15:0];
            m_acc_i = 0;
            m_acc_q = 0;
            m_count = 0;
            m_slip  = 1'b1;
         end else begin
            m_acc_i = sum_i;
            m_acc_q = sum_q;
            m_count++;
            m_slip  = 1'b0;
         end
      end
   endtask

   task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
      check_cnt++;
      assert (got === exp) else begin
         $display("MISMATCH %s got %h expected %h at cycle %0d", name, got, exp, cycle_cnt);
         err_cnt++;
      end
   endtask

   task automatic check_word(input string name, input wb_dat_t got, input wb_dat_t exp);
      check_cnt++;
      assert (got === exp) else begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_true(input logic ok, input string what);
      check_cnt++;
      assert (ok === 1'b1) else begin
         $display("ERROR %s at cycle %0d", what, cycle_cnt);
         err_cnt++;
      end
   endtask

   // Advance one clock and compare whatever is due
   task automatic tick();
      @(posedge clk_i);
      #10;
      if (dac_due) begin
         check_val("tx_dac_i_o", tx_dac_i_o, dac_exp);
         check_val("tx_dac_q_o", tx_dac_q_o, 16'h0000);
         dac_seen.push_back(tx_dac_i_o);
         dac_due = 1'b0;
      end
      if (rx_strobe_o === 1'b1) begin
         imp_seen.push_back(rx_imp_i_o);            // Every pulse the DUT gives
      end
      if (imp_due.size() > 0 && imp_due[0] == cycle_cnt) begin
         check_true(rx_strobe_o, "rx_strobe_o missing at the end of a code period");
         check_val("rx_imp_i_o", rx_imp_i_o, imp_exp_i[0]);
         check_val("rx_imp_q_o", rx_imp_q_o, imp_exp_q[0]);
         void'(imp_due.pop_front());
         void'(imp_exp_i.pop_front());
         void'(imp_exp_q.pop_front());
      end else begin
         check_true(!rx_strobe_o, "rx_strobe_o pulsed with no code period completed");
      end
   endtask

   task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                             output wb_dat_t rdat);
      int acks;
      int waited;
      acks     = 0;
      waited   = 0;
      rdat     = '0;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      do begin
         tick();
         waited++;
      end while (!wb_ack_o && waited < 8);
      if (wb_ack_o) begin
         acks++;
         rdat = wb_dat_o;                        // Valid while ack is high
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      tick();
      if (wb_ack_o) acks++;
      check_true(acks == 1, "Wishbone access did not ack exactly once");
      if (we) begin                                // Mirror the register map
         if (adr == REG_DEGREE) m_degree = wdat[DEGREE_W-1:0];
         if (adr == REG_MODE) m_loopback = wdat[MODE_LOOPBACK];
         m_mask = taps_for(m_degree);
         m_len  = (m_mask == '0) ? 0 : (1 << m_degree) - 1;
      end
   endtask

   task automatic reg_write(input wb_adr_t adr, input wb_dat_t data);
      wb_dat_t dummy;
      bus_access(1'b1, adr, data, dummy);
   endtask

   task automatic reg_read(input wb_adr_t adr, input wb_dat_t exp);
      wb_dat_t got;
      bus_access(1'b0, adr, '0, got);
      check_word("wb_dat_o", got, exp);
   endtask

   task automatic set_enables(input logic on);
      tx_enable_i = on;
      rx_enable_i = on;
      if (!on) model_restart();                    // Idle returns both coders to seed
      tick();
   endtask

   // Strobes on both converters, spaced 1 to 4 cycles
   task automatic send_strobes(input int n);
      int          gap;
      sample_t     adc_i, adc_q, ei, eq;
      logic [15:0] dexp;
      logic        fire;
      for (int k = 0; k < n; k++) begin
         adc_i = sample_t'($urandom_range(16382)) - 16'sd8191;
         adc_q = sample_t'($urandom_range(16382)) - 16'sd8191;
         model_strobe(adc_i, adc_q, dexp, fire, ei, eq);
         tx_strobe_i = 1'b1;
         rx_strobe_i = 1'b1;
         rx_adc_i_i  = adc_i;
         rx_adc_q_i  = adc_q;
         dac_exp     = dexp;
         dac_due     = 1'b1;
         if (fire) begin
            imp_due.push_back(cycle_cnt + (m_loopback ? 2 : 1));   // Extra stage in loopback
            imp_exp_i.push_back(ei);
            imp_exp_q.push_back(eq);
         end
         gap = int'($urandom_range(4, 1));
         tick();
         tx_strobe_i = 1'b0;
         rx_strobe_i = 1'b0;
         repeat (gap - 1) tick();
      end
   endtask

   task automatic drain();
      repeat (4) tick();
   endtask

   task automatic begin_test();
      err_base = err_cnt;
      test_num++;
      dac_seen.delete();
      imp_seen.delete();
   endtask

   task automatic end_test(input string name);
      if (err_cnt == err_base) begin
         test_pass++;
         $display("Test %0d %s: passed", test_num, name);
      end else begin
         test_fail++;
         $display("Test %0d %s: FAILED with %0d errors", test_num, name, err_cnt - err_base);
      end
   endtask

   initial begin
      clk_i       = 1'b0;
      rst_n_i     = 1'b0;
      wb_cyc_i    = 1'b0;
      wb_stb_i    = 1'b0;
      wb_we_i     = 1'b0;
      wb_adr_i    = '0;
      wb_dat_i    = '0;
      tx_enable_i = 1'b0;
      tx_strobe_i = 1'b0;
      rx_enable_i = 1'b0;
      rx_strobe_i = 1'b0;
      rx_adc_i_i  = '0;
      rx_adc_q_i  = '0;
      void'($urandom(48414));
      m_degree   = '0;
      m_loopback = 1'b0;
      m_mask     = '0;
      m_len      = 0;
      dac_due    = 1'b0;
      model_restart();
      repeat (2) tick();                           // Reset over two edges
      rst_n_i = 1'b1;
      check_val("tx_dac_i_o", tx_dac_i_o, 16'h0000);
      check_true(!wb_ack_o, "wb_ack_o high after reset");

      begin_test();
      reg_write(REG_DEGREE, 32'hFFFF_FFE5);       // Only the low 5 bits stick
      reg_read(REG_DEGREE, 32'h0000_0005);
      reg_write(REG_MODE, 32'hFFFF_FFFF);
      reg_read(REG_MODE, 32'h0000_0001);
      reg_write(4'd7, 32'hA5A5_A5A5);
      reg_read(4'd7, 32'h0000_0000);
      reg_read(REG_DEGREE, 32'h0000_0005);
      reg_write(REG_MODE, 32'h0000_0000);
      reg_read(REG_MODE, 32'h0000_0000);
      end_test("register access");

      begin_test();
      set_enables(1'b1);                           // Degree 5 already set
      send_strobes(T2_STB);
      drain();
      for (int k = 31; k < dac_seen.size(); k++) begin
         check_val("tx_dac_i_o repeat", dac_seen[k], dac_seen[k-31]);
      end
      set_enables(1'b0);
      end_test("degree 5 chip sequence");

      begin_test();
      reg_write(REG_MODE, 32'h0000_0001);
      reg_write(REG_DEGREE, 32'd4);
      set_enables(1'b1);
      send_strobes(T3_STB);
      drain();
      check_true(imp_seen.size() == 15, "expected 15 impulse outputs in loopback");
      for (int k = 1; k < imp_seen.size(); k++) begin
         check_true(imp_seen[0] > imp_seen[k], "lag 0 is not the largest I output");
      end
      set_enables(1'b0);
      end_test("loopback impulse sweep");

      begin_test();
      reg_write(REG_MODE, 32'h0000_0000);
      reg_write(REG_DEGREE, 32'd3);
      set_enables(1'b1);
      send_strobes(T4_STB);
      drain();
      check_true(imp_seen.size() == 8, "expected 8 impulse outputs from ADC input");
      set_enables(1'b0);
      end_test("random ADC correlation");

      begin_test();
      reg_write(REG_DEGREE, 32'd1);
      set_enables(1'b1);
      send_strobes(T5_STB / 2);
      drain();
      set_enables(1'b0);
      reg_write(REG_DEGREE, 32'd17);
      set_enables(1'b1);
      send_strobes(T5_STB / 2);
      drain();
      check_true(imp_seen.size() == 0, "impulse output with an invalid degree");
      set_enables(1'b0);
      end_test("invalid degree idle");

      begin_test();
      reg_write(REG_DEGREE, 32'd3);
      set_enables(1'b1);
      send_strobes(10);                            // Stop inside the second period
      drain();
      set_enables(1'b0);
      set_enables(1'b1);
      dac_seen.delete();
      send_strobes(T6_STB - 10);
      drain();
      check_val("tx_dac_i_o after restart", dac_seen[0], CHIP_AMP);   // Seed chip is 1
      set_enables(1'b0);
      end_test("enable restart");

      $display("Tests %0d, passed %0d, failed %0d, checks %0d, errors %0d, assertion fails %0d",
               test_num, test_pass, test_fail, check_cnt, err_cnt, dut_i.chk_i.fail_cnt);
      if (err_cnt == 0 && dut_i.chk_i.fail_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
sounder_pkg.sv
sounder_regs_pkg.sv
sounder_regs.sv
lfsr_constants.sv
sounder_tx.sv
sounder_rx.sv
sounder.sv
sounder_chk.sv
tb_sounder.sv

//--- Makefile
# Verilator build and run for the channel sounder

VERILATOR ?= verilator
TOP       ?= tb_sounder
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
